// File: common/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

`define UART_DATA_W   32   // One APB word
`define UART_ADDR_W   12
`define UART_MIN_BAUD 4    // Smaller BRR values are raised to this

// Control register fields
`define UART_CR_EN      0
`define UART_CR_TXEN    1
`define UART_CR_RXEN    2
`define UART_CR_PAR_EN  3
`define UART_CR_PAR_ODD 4
`define UART_CR_STOP2   5
`define UART_CR_LEN_LO  8
`define UART_CR_LEN_HI  11

// Status and interrupt enable bits share positions
`define UART_SR_TXE  0     // TX buffer empty
`define UART_SR_RXF  1     // RX buffer full
`define UART_IER_TXE 0
`define UART_IER_RXF 1

`endif

// File: common/uart_bus_pkg.sv
`include "uart_settings.svh"

package uart_bus_pkg;

    typedef logic [`UART_DATA_W-1:0]   uart_word_t;
    typedef logic [`UART_ADDR_W-1:0]   uart_addr_t;
    typedef logic [`UART_DATA_W/8-1:0] uart_strb_t;

    // Word index of each register
    typedef enum logic [2:0] {
        DR  = 3'd0,
        CR  = 3'd1,
        SR  = 3'd2,
        BRR = 3'd3,
        IER = 3'd4
    } uart_reg_idx_e;

    // Requester side of an APB transfer
    typedef struct packed {
        uart_addr_t paddr;
        logic       psel;
        logic       penable;
        logic       pwrite;
        uart_word_t pwdata;
        uart_strb_t pstrb;
    } apb_req_t;

    // Completer side
    typedef struct packed {
        uart_word_t prdata;
        logic       pready;
        logic       pslverr;
    } apb_rsp_t;

endpackage

// File: common/uart_line_pkg.sv
`include "uart_settings.svh"

package uart_line_pkg;

    // Frame format as seen by both directions
    typedef struct packed {
        logic [`UART_CR_LEN_HI-`UART_CR_LEN_LO:0] data_len;  // 5 to 8, else 8
        logic                                     par_en;
        logic                                     par_odd;
        logic                                     stop2;
    } frame_cfg_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    // Number of data bits, out-of-range lengths fall back to 8
    function automatic logic [3:0] frame_len(frame_cfg_t cfg);
        if (cfg.data_len >= 4'd5 && cfg.data_len <= 4'd8) begin
            return cfg.data_len;
        end
        return 4'd8;
    endfunction

endpackage

// File: rtl/uart_baud_timer.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_baud_timer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     run,
    input  logic                     restart,
    input  uart_bus_pkg::uart_word_t baud_div,
    output logic                     mid_tick,
    output logic                     bit_tick
);
    import uart_bus_pkg::*;

    uart_word_t div_eff;
    uart_word_t cnt;

    // Bit period in clock cycles
    assign div_eff = (baud_div < uart_word_t'(`UART_MIN_BAUD)) ?
                     uart_word_t'(`UART_MIN_BAUD) : baud_div;

    assign mid_tick = run && (cnt == (div_eff >> 1));
    assign bit_tick = run && (cnt == '0);   // Last cycle of the bit

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (restart) begin
            cnt <= div_eff - 1'b1;
        end else if (run) begin
            if (cnt == '0) begin
                cnt <= div_eff - 1'b1;   // Next bit
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      enable,
    input  uart_line_pkg::frame_cfg_t cfg,
    input  uart_bus_pkg::uart_word_t  baud_div,
    input  uart_bus_pkg::uart_word_t  tx_data,
    input  logic                      tx_valid,
    output logic                      tx_ready,
    output logic                      tx_busy,
    output logic                      txd
);
    import uart_line_pkg::*;

    tx_state_e  state;
    logic [7:0] shift;
    logic [3:0] bit_cnt;     // Data bits already on the line
    logic       stop_cnt;
    logic       par;
    logic       bit_tick;
    logic [3:0] len;

    assign len      = frame_len(cfg);
    assign tx_ready = (state == TX_IDLE) && enable && tx_valid;
    assign tx_busy  = (state != TX_IDLE);

    uart_baud_timer i_timer (
        .clk      (clk),
        .rst      (rst),
        .run      (tx_busy),
        .restart  (tx_ready),
        .baud_div (baud_div),
        .mid_tick (),
        .bit_tick (bit_tick)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
            par      <= 1'b0;
            txd      <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_ready) begin
                        shift <= tx_data[7:0];
                        par   <= cfg.par_odd;   // Odd parity starts from one
                        txd   <= 1'b0;          // Start bit
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_tick) begin
                        txd     <= shift[0];
                        par     <= par ^ shift[0];
                        shift   <= shift >> 1;
                        bit_cnt <= 4'd1;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_tick && bit_cnt == len) begin
                        if (cfg.par_en) begin
                            txd   <= par;
                            state <= TX_PARITY;
                        end else begin
                            txd      <= 1'b1;
                            stop_cnt <= 1'b0;
                            state    <= TX_STOP;
                        end
                    end else if (bit_tick) begin
                        txd     <= shift[0];   // LSB first
                        par     <= par ^ shift[0];
                        shift   <= shift >> 1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                TX_PARITY: begin
                    if (bit_tick) begin
                        txd      <= 1'b1;
                        stop_cnt <= 1'b0;
                        state    <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    if (bit_tick) begin
                        if (cfg.stop2 && !stop_cnt) begin
                            stop_cnt <= 1'b1;
                        end else begin
                            state <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

// File: uart/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      enable,
    input  uart_line_pkg::frame_cfg_t cfg,
    input  uart_bus_pkg::uart_word_t  baud_div,
    input  logic                      rxd,
    output uart_bus_pkg::uart_word_t  rx_data,
    output logic                      rx_valid,
    input  logic                      rx_ready,
    output logic                      rx_busy
);
    import uart_bus_pkg::*;
    import uart_line_pkg::*;

    rx_state_e  state;
    logic       rxd_meta;
    logic       rxd_s;
    logic [7:0] shift;       // Bits enter at the top
    logic [3:0] bit_cnt;
    logic       stop_cnt;
    logic       mid_tick;
    logic       bit_tick;
    logic       start_det;
    logic       frame_end;
    logic [3:0] len;

    assign len       = frame_len(cfg);
    assign rx_busy   = (state != RX_IDLE);
    assign start_det = (state == RX_IDLE) && enable && !rxd_s;
    // Middle of the last stop bit
    assign frame_end = (state == RX_STOP) && mid_tick && (!cfg.stop2 || stop_cnt);

    uart_baud_timer i_timer (
        .clk      (clk),
        .rst      (rst),
        .run      (rx_busy),
        .restart  (start_det),
        .baud_div (baud_div),
        .mid_tick (mid_tick),
        .bit_tick (bit_tick)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
        end
    end

    // Right-aligned result, upper bits zero
    always_ff @(posedge clk) begin
        if (frame_end) begin
            rx_data <= uart_word_t'(shift) >> (4'd8 - len);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= frame_end && rx_ready;   // Dropped when buffer is full
            case (state)
                RX_IDLE: begin
                    if (start_det) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_tick && rxd_s) begin
                        state <= RX_IDLE;     // Glitch, not a start bit
                    end else if (bit_tick) begin
                        bit_cnt <= '0;
                        state   <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (mid_tick) begin
                        shift   <= {rxd_s, shift[7:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (bit_tick && bit_cnt == len) begin
                        stop_cnt <= 1'b0;
                        state    <= cfg.par_en ? RX_PARITY : RX_STOP;
                    end
                end
                RX_PARITY: begin
                    if (bit_tick) begin
                        state <= RX_STOP;     // Parity value is ignored
                    end
                end
                RX_STOP: begin
                    if (frame_end) begin
                        state <= RX_IDLE;
                    end else if (bit_tick) begin
                        stop_cnt <= 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: uart/uart_regs.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  uart_bus_pkg::apb_req_t    apb_req,
    output uart_bus_pkg::apb_rsp_t    apb_rsp,
    output uart_line_pkg::frame_cfg_t cfg,
    output logic                      tx_en,
    output logic                      rx_en,
    output uart_bus_pkg::uart_word_t  baud_div,
    output uart_bus_pkg::uart_word_t  tx_data,
    output logic                      tx_valid,
    input  logic                      tx_ready,
    input  logic                      tx_busy,
    input  uart_bus_pkg::uart_word_t  rx_data,
    input  logic                      rx_valid,
    output logic                      rx_ready,
    input  logic                      rx_busy,
    output logic                      irq
);
    import uart_bus_pkg::*;

    uart_word_t    cr_q;
    uart_word_t    brr_q;
    uart_word_t    ier_q;
    uart_word_t    sr_val;
    uart_word_t    tx_buf;
    uart_word_t    rx_buf;
    logic          tx_empty;
    logic          rx_full;
    uart_word_t    prdata_q;
    logic          pready_q;
    logic          pslverr_q;
    uart_word_t    mask;
    uart_word_t    new_cr;
    uart_reg_idx_e idx;
    logic          idx_ok;
    logic          pending;
    logic          cr_wait;      // CR write that changes the frame setting

    always_comb begin
        for (int i = 0; i < `UART_DATA_W/8; i++) begin
            mask[i*8 +: 8] = apb_req.pstrb[i] ? 8'hff : 8'h00;
        end
        new_cr = (apb_req.pwdata & mask) | (cr_q & ~mask);
        sr_val = '0;
        sr_val[`UART_SR_TXE] = tx_empty;
        sr_val[`UART_SR_RXF] = rx_full;
    end

    assign idx     = uart_reg_idx_e'(apb_req.paddr[4:2]);
    assign idx_ok  = (apb_req.paddr[`UART_ADDR_W-1:5] == '0);
    assign pending = apb_req.psel && !pready_q;
    assign cr_wait = pending && apb_req.pwrite && idx_ok && (idx == CR) && (new_cr != cr_q);

    assign apb_rsp = '{prdata: prdata_q, pready: pready_q, pslverr: pslverr_q};

    assign cfg.data_len = cr_q[`UART_CR_LEN_HI:`UART_CR_LEN_LO];
    assign cfg.par_en   = cr_q[`UART_CR_PAR_EN];
    assign cfg.par_odd  = cr_q[`UART_CR_PAR_ODD];
    assign cfg.stop2    = cr_q[`UART_CR_STOP2];

    // No new frame may start while a CR change is waiting
    assign tx_en    = cr_q[`UART_CR_EN] && cr_q[`UART_CR_TXEN] && !cr_wait;
    assign rx_en    = cr_q[`UART_CR_EN] && cr_q[`UART_CR_RXEN] && !cr_wait;
    assign baud_div = brr_q;
    assign tx_data  = tx_buf;
    assign tx_valid = !tx_empty;
    assign rx_ready = !rx_full;

    assign irq = cr_q[`UART_CR_EN] &&
                 ((tx_empty && ier_q[`UART_IER_TXE]) || (rx_full && ier_q[`UART_IER_RXF]));

    always_ff @(posedge clk) begin
        if (rst) begin
            cr_q      <= '0;
            brr_q     <= '0;
            ier_q     <= '0;
            tx_empty  <= 1'b1;
            rx_full   <= 1'b0;
            prdata_q  <= '0;
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            if (pending && !idx_ok) begin
                pready_q  <= 1'b1;
                pslverr_q <= 1'b1;
            end else if (pending) begin
                case (idx)
                    DR: begin
                        pready_q <= 1'b1;
                        if (apb_req.pwrite && tx_en && tx_empty) begin
                            tx_buf   <= apb_req.pwdata;
                            tx_empty <= 1'b0;
                        end else if (!apb_req.pwrite && rx_en && rx_full) begin
                            prdata_q <= rx_buf;
                            rx_full  <= 1'b0;
                        end else begin
                            pslverr_q <= 1'b1;   // Buffer not ready or disabled
                        end
                    end
                    CR: begin
                        if (!apb_req.pwrite) begin
                            prdata_q <= cr_q;
                            pready_q <= 1'b1;
                        end else if (!(cr_wait && (tx_busy || rx_busy))) begin
                            cr_q     <= new_cr;   // Held off while a frame runs
                            pready_q <= 1'b1;
                        end
                    end
                    SR: begin
                        pready_q <= 1'b1;
                        if (apb_req.pwrite) begin
                            pslverr_q <= 1'b1;
                        end else begin
                            prdata_q <= sr_val;
                        end
                    end
                    BRR: begin
                        pready_q <= 1'b1;
                        if (apb_req.pwrite) begin
                            brr_q <= (apb_req.pwdata & mask) | (brr_q & ~mask);
                        end else begin
                            prdata_q <= brr_q;
                        end
                    end
                    IER: begin
                        pready_q <= 1'b1;
                        if (apb_req.pwrite) begin
                            ier_q <= (apb_req.pwdata & mask) | (ier_q & ~mask);
                        end else begin
                            prdata_q <= ier_q;
                        end
                    end
                    default: begin
                        pready_q  <= 1'b1;
                        pslverr_q <= 1'b1;
                    end
                endcase
            end else if (apb_req.psel && apb_req.penable && pready_q) begin
                prdata_q  <= '0;
                pready_q  <= 1'b0;
                pslverr_q <= 1'b0;
            end

            // Handshakes never collide with the bus updates above
            if (tx_valid && tx_ready) begin
                tx_empty <= 1'b1;
            end
            if (rx_valid && rx_ready) begin
                rx_full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && rx_ready) begin
            rx_buf <= rx_data;
        end
    end

endmodule

// File: uart/uart_top.sv
`timescale 1ns/100ps

module uart_top (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_bus_pkg::apb_req_t apb_req,
    output uart_bus_pkg::apb_rsp_t apb_rsp,
    output logic                   irq,
    output logic                   txd,
    input  logic                   rxd
);
    import uart_bus_pkg::*;
    import uart_line_pkg::*;

    frame_cfg_t cfg;
    uart_word_t baud_div;
    uart_word_t tx_data;
    uart_word_t rx_data;
    logic       tx_en;
    logic       rx_en;
    logic       tx_valid;
    logic       tx_ready;
    logic       tx_busy;
    logic       rx_valid;
    logic       rx_ready;
    logic       rx_busy;

    uart_regs i_regs (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .cfg      (cfg),
        .tx_en    (tx_en),
        .rx_en    (rx_en),
        .baud_div (baud_div),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_busy  (tx_busy),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_busy  (rx_busy),
        .irq      (irq)
    );

    uart_tx i_tx (
        .clk      (clk),
        .rst      (rst),
        .enable   (tx_en),
        .cfg      (cfg),
        .baud_div (baud_div),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_busy  (tx_busy),
        .txd      (txd)
    );

    uart_rx i_rx (
        .clk      (clk),
        .rst      (rst),
        .enable   (rx_en),
        .cfg      (cfg),
        .baud_div (baud_div),
        .rxd      (rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_busy  (rx_busy)
    );

endmodule

// File: tests/uart_properties.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_properties (
    input logic                   clk,
    input logic                   rst,
    input uart_bus_pkg::apb_req_t apb_req,
    input uart_bus_pkg::apb_rsp_t apb_rsp,
    input logic                   irq,
    input logic                   txd,
    input logic                   tx_en
);
    import uart_bus_pkg::*;

    logic tx_seen;   // TX enabled at least once since reset
    logic cr_wr;     // CR write completing in this cycle
    logic en_q;      // EN as last written over APB
    logic en_now;

    assign cr_wr  = apb_req.psel && apb_req.penable && apb_req.pwrite && apb_rsp.pready &&
                    !apb_rsp.pslverr && (apb_req.paddr[4:2] == CR) &&
                    (apb_req.paddr[`UART_ADDR_W-1:5] == '0) && apb_req.pstrb[0];
    assign en_now = cr_wr ? apb_req.pwdata[`UART_CR_EN] : en_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_seen <= 1'b0;
        end else if (tx_en) begin
            tx_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q <= 1'b0;
        end else if (cr_wr) begin
            en_q <= apb_req.pwdata[`UART_CR_EN];
        end
    end

    pready_one_cycle: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pready |=> !apb_rsp.pready)
        else $error("pready stayed high for more than one cycle");

    txd_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_seen |-> txd)
        else $error("txd left idle before TX was enabled");

    irq_needs_en: assert property (@(posedge clk) disable iff (rst) irq |-> en_now)
        else $error("irq high while EN is clear");

endmodule

bind uart_top uart_properties i_props (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .irq     (irq),
    .txd     (txd),
    .tx_en   (tx_en)
);

// File: tests/uart_tb.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_tb;
    import uart_bus_pkg::*;

    localparam int CLK_NS     = 10;
    localparam int BIT_D      = 8;     // Clock cycles per bit
    localparam int FRAME_BITS = 71;    // All bits of all frames in the run
    localparam int FRAME_NS   = 10 * BIT_D * CLK_NS;
    localparam int TIMEOUT_NS = FRAME_BITS * BIT_D * CLK_NS * 2 + 5000;

    // One row of the register table
    typedef struct packed {
        logic       wr;
        logic [2:0] idx;
        logic [3:0] strb;
        uart_word_t wdata;
        uart_word_t rdata;
        logic       err;
    } step_t;

    logic     clk;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     irq;
    logic     txd;
    logic     rxd;
    logic     rxd_drv;
    logic     rx_from_tb;   // Task drives rxd instead of loopback

    step_t  steps[$];
    integer seed;
    int     checks;
    int     errors;
    int     err_mark;
    int     tests;
    int     cfg_len;
    logic   cfg_par;
    logic   cfg_odd;
    logic   cfg_stop2;

    assign rxd = rx_from_tb ? rxd_drv : txd;

    uart_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .irq     (irq),
        .txd     (txd),
        .rxd     (rxd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_val(input uart_word_t got, input uart_word_t exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_val(uart_word_t'(got), uart_word_t'(exp), what);
    endtask

    function automatic step_t make_step(input logic wr, input logic [2:0] idx,
                                        input logic [3:0] strb, input uart_word_t wdata,
                                        input uart_word_t rdata, input logic err);
        return '{wr: wr, idx: idx, strb: strb, wdata: wdata, rdata: rdata, err: err};
    endfunction

    function automatic uart_word_t low_bits(input logic [7:0] data, input int len);
        return uart_word_t'(data) & ((uart_word_t'(1) << len) - 1);
    endfunction

    function automatic uart_word_t cr_value(input logic en, input logic txen, input logic rxen,
                                            input int len, input logic par, input logic odd,
                                            input logic stop2);
        uart_word_t cr;
        cr = '0;
        cr[`UART_CR_EN]      = en;
        cr[`UART_CR_TXEN]    = txen;
        cr[`UART_CR_RXEN]    = rxen;
        cr[`UART_CR_PAR_EN]  = par;
        cr[`UART_CR_PAR_ODD] = odd;
        cr[`UART_CR_STOP2]   = stop2;
        cr[`UART_CR_LEN_HI:`UART_CR_LEN_LO] = 4'(len);
        return cr;
    endfunction

    // Setup phase, then access phase held until pready
    task automatic apb_access(input logic wr, input logic [2:0] idx, input logic [3:0] strb,
                              input uart_word_t wdata, output uart_word_t rdata,
                              output logic err);
        @(posedge clk);
        apb_req.paddr   <= uart_addr_t'({idx, 2'b00});
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.pwdata  <= wdata;
        apb_req.pstrb   <= strb;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic run_step(input step_t s);
        uart_word_t rd;
        logic       err;
        apb_access(s.wr, s.idx, s.strb, s.wdata, rd, err);
        check_bit(err, s.err, $sformatf("pslverr at index %0d", s.idx));
        if (!s.wr && !s.err) begin
            check_val(rd, s.rdata, $sformatf("read data at index %0d", s.idx));
        end
    endtask

    task automatic reg_write(input logic [2:0] idx, input uart_word_t data);
        run_step(make_step(1'b1, idx, 4'hf, data, '0, 1'b0));
    endtask

    task automatic expect_read(input logic [2:0] idx, input uart_word_t exp, input logic err);
        run_step(make_step(1'b0, idx, 4'h0, '0, exp, err));
    endtask

    task automatic set_frame(input logic en, input logic txen, input logic rxen, input int len,
                             input logic par, input logic odd, input logic stop2);
        reg_write(CR, cr_value(en, txen, rxen, len, par, odd, stop2));
        cfg_len   = len;
        cfg_par   = par;
        cfg_odd   = odd;
        cfg_stop2 = stop2;
    endtask

    // Samples one frame on txd near the middle of each bit
    task automatic expect_tx_frame(input logic [7:0] data);
        logic par;
        int   n;
        par = cfg_odd ^ (^low_bits(data, cfg_len));
        @(negedge txd);
        repeat (BIT_D / 2) @(negedge clk);
        check_bit(txd, 1'b0, "start bit");
        for (n = 0; n < cfg_len; n++) begin
            repeat (BIT_D) @(negedge clk);
            check_bit(txd, data[n], $sformatf("data bit %0d", n));
        end
        if (cfg_par) begin
            repeat (BIT_D) @(negedge clk);
            check_bit(txd, par, "parity bit");
        end
        repeat (BIT_D) @(negedge clk);
        check_bit(txd, 1'b1, "stop bit");
        if (cfg_stop2) begin
            repeat (BIT_D) @(negedge clk);
            check_bit(txd, 1'b1, "second stop bit");
        end
    endtask

    task automatic drive_rx_frame(input logic [7:0] data);
        logic par;
        int   n;
        par = cfg_odd;
        @(posedge clk);
        rxd_drv <= 1'b0;   // Start bit
        for (n = 0; n < cfg_len; n++) begin
            repeat (BIT_D) @(posedge clk);
            rxd_drv <= data[n];
            par = par ^ data[n];
        end
        if (cfg_par) begin
            repeat (BIT_D) @(posedge clk);
            rxd_drv <= par;
        end
        repeat (BIT_D) @(posedge clk);
        rxd_drv <= 1'b1;
        repeat (cfg_stop2 ? 2 * BIT_D : BIT_D) @(posedge clk);
    endtask

    task automatic wait_rx_full();
        uart_word_t sr;
        logic       err;
        sr = '0;
        while (!sr[`UART_SR_RXF]) begin
            apb_access(1'b0, SR, 4'h0, '0, sr, err);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        uart_word_t rd;
        logic       err;
        logic [7:0] b0;
        logic [7:0] b1;
        time        t_start;
        time        t_done;
        int         i;

        seed       = 65;
        checks     = 0;
        errors     = 0;
        err_mark   = 0;
        tests      = 0;
        cfg_len    = 8;
        cfg_par    = 1'b0;
        cfg_odd    = 1'b0;
        cfg_stop2  = 1'b0;
        apb_req    = '0;
        rst        = 1'b1;
        rxd_drv    = 1'b1;
        rx_from_tb = 1'b1;
        repeat (8) @(posedge clk);
        rst        <= 1'b0;
        rx_from_tb <= 1'b0;
        @(negedge clk);
        check_bit(irq, 1'b0, "irq after reset");

        // Reset values, byte strobes and error responses
        steps.push_back(make_step(1'b0, SR, 4'h0, '0, 32'h1, 1'b0));
        steps.push_back(make_step(1'b0, CR, 4'h0, '0, '0, 1'b0));
        steps.push_back(make_step(1'b0, BRR, 4'h0, '0, '0, 1'b0));
        steps.push_back(make_step(1'b0, IER, 4'h0, '0, '0, 1'b0));
        steps.push_back(make_step(1'b1, BRR, 4'b0101, 32'ha1b2c3d4, '0, 1'b0));
        steps.push_back(make_step(1'b0, BRR, 4'h0, '0, 32'h00b200d4, 1'b0));
        steps.push_back(make_step(1'b1, IER, 4'b0010, 32'h12345678, '0, 1'b0));
        steps.push_back(make_step(1'b0, IER, 4'h0, '0, 32'h00005600, 1'b0));
        steps.push_back(make_step(1'b1, SR, 4'hf, 32'h3, '0, 1'b1));
        steps.push_back(make_step(1'b0, 3'd5, 4'h0, '0, '0, 1'b1));
        steps.push_back(make_step(1'b0, DR, 4'h0, '0, '0, 1'b1));     // RX empty
        steps.push_back(make_step(1'b1, DR, 4'hf, 32'h55, '0, 1'b1)); // TX disabled
        steps.push_back(make_step(1'b1, IER, 4'hf, '0, '0, 1'b0));
        steps.push_back(make_step(1'b0, IER, 4'h0, '0, '0, 1'b0));
        foreach (steps[k]) begin
            run_step(steps[k]);
        end
        finish_test("registers");

        reg_write(BRR, BIT_D);
        set_frame(1'b1, 1'b1, 1'b0, 8, 1'b0, 1'b0, 1'b0);
        b0 = 8'($random(seed));
        b1 = 8'($random(seed));
        fork
            begin
                expect_tx_frame(b0);
                expect_tx_frame(b1);
            end
            begin
                reg_write(DR, uart_word_t'(b0));
                reg_write(DR, uart_word_t'(b1));   // Waits in the buffer
                run_step(make_step(1'b1, DR, 4'hf, 32'h5a, '0, 1'b1));
            end
        join
        finish_test("tx frame");

        set_frame(1'b1, 1'b1, 1'b0, 7, 1'b1, 1'b1, 1'b1);
        b0 = 8'($random(seed));
        fork
            expect_tx_frame(b0);
            reg_write(DR, uart_word_t'(b0));
        join
        finish_test("tx parity and length");

        @(posedge clk);
        rx_from_tb <= 1'b1;
        set_frame(1'b1, 1'b0, 1'b1, 8, 1'b0, 1'b0, 1'b0);
        expect_read(DR, '0, 1'b1);
        for (i = 0; i < 2; i++) begin
            if (i == 1) begin
                set_frame(1'b1, 1'b0, 1'b1, 6, 1'b1, 1'b0, 1'b1);
            end
            b0 = 8'($random(seed));
            drive_rx_frame(b0);
            wait_rx_full();
            expect_read(DR, low_bits(b0, cfg_len), 1'b0);
        end
        finish_test("rx frames");

        @(posedge clk);
        rx_from_tb <= 1'b0;
        set_frame(1'b1, 1'b1, 1'b1, 8, 1'b0, 1'b0, 1'b0);
        reg_write(IER, 32'h3);
        @(negedge clk);
        check_bit(irq, 1'b1, "irq with TX empty");
        reg_write(IER, 32'h2);
        @(negedge clk);
        check_bit(irq, 1'b0, "irq with TX source masked");
        b0 = 8'($random(seed));
        reg_write(DR, uart_word_t'(b0));
        wait_rx_full();
        @(negedge clk);
        check_bit(irq, 1'b1, "irq with RX full");
        expect_read(DR, uart_word_t'(b0), 1'b0);
        @(negedge clk);
        check_bit(irq, 1'b0, "irq after DR read");
        reg_write(IER, 32'h3);
        reg_write(CR, cr_value(1'b0, 1'b1, 1'b1, 8, 1'b0, 1'b0, 1'b0));
        @(negedge clk);
        check_bit(irq, 1'b0, "irq with EN cleared");
        finish_test("loopback irq");

        set_frame(1'b1, 1'b1, 1'b0, 8, 1'b0, 1'b0, 1'b0);
        b0 = 8'($random(seed));
        fork
            begin
                @(negedge txd);
                t_start = $time;
            end
            begin
                reg_write(DR, uart_word_t'(b0));
                apb_access(1'b1, CR, 4'hf, cr_value(1'b1, 1'b1, 1'b0, 5, 1'b0, 1'b0, 1'b0),
                           rd, err);
                t_done = $time;
                check_bit(err, 1'b0, "pslverr of stalled CR write");
            end
        join
        check_bit((t_done - t_start) >= FRAME_NS, 1'b1, "CR write held until frame end");
        @(negedge clk);
        check_bit(txd, 1'b1, "txd after stalled CR write");
        expect_read(CR, cr_value(1'b1, 1'b1, 1'b0, 5, 1'b0, 1'b0, 1'b0), 1'b0);
        finish_test("cr stall");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/uart_bus_pkg.sv
common/uart_line_pkg.sv
rtl/uart_baud_timer.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_regs.sv
uart/uart_top.sv
tests/uart_properties.sv
tests/uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module uart_tb
./obj_dir/Vuart_tb | tee /dev/stderr | grep "Simulation passed" > /dev/null
